// ==== build.f ====
hdl/uf_pkg.sv
hdl/min_root_select.sv
hdl/processing_unit.sv
hdl/edge_link.sv
hdl/stage_controller.sv
hdl/uf_decoder_top.sv
tb/tb_uf_decoder.sv

// ==== hdl/edge_link.sv ====
`timescale 1ns/1ps

module edge_link #(
    parameter bit IS_BOUNDARY = 1'b0
) (
    input  logic           clk,
    input  logic           reset,
    input  uf_pkg::stage_t global_stage,
    input  logic           increase_left,
    input  logic           increase_right,
    input  logic           error_left,
    input  logic           error_right,
    output logic           fully_grown,
    output logic           is_boundary,
    output logic           correction
);

    import uf_pkg::*;

    stage_t stage;
    growth_t growth;
    logic [2:0] growth_sum;

    // Follows the units' view of the stage
    always_ff @(posedge clk) begin
        if (reset) begin
            stage <= STAGE_IDLE;
        end else begin
            stage <= global_stage;
        end
    end

    assign growth_sum = growth + increase_left + increase_right;

    always_ff @(posedge clk) begin
        if (reset || (stage == STAGE_MEASUREMENT_LOADING)) begin
            growth <= '0;
        end else if (stage == STAGE_GROW) begin
            // Saturate at full
            growth <= (growth_sum > 3'(GROWTH_FULL)) ? GROWTH_FULL : growth_t'(growth_sum);
        end
    end

    assign fully_grown = (growth == GROWTH_FULL);
    assign is_boundary = IS_BOUNDARY && fully_grown;
    assign correction  = error_left | error_right;

    // A boundary edge has a unit on one side only
    assert property (@(posedge clk) disable iff (reset)
        IS_BOUNDARY |-> !(increase_left && increase_right));

endmodule

// ==== hdl/min_root_select.sv ====
`timescale 1ns/1ps

module min_root_select (
    input  uf_pkg::root_addr_t [uf_pkg::NEIGHBOR_COUNT-1:0] values,
    input  uf_pkg::neighbor_vec_t                           valids,
    output uf_pkg::root_addr_t                              result,
    output uf_pkg::neighbor_vec_t                           output_valids
);

    import uf_pkg::*;

    // Smallest root among the valid neighbors
    always_comb begin
        result = '1;
        for (int k = 0; k < NEIGHBOR_COUNT; k++) begin
            if (valids[k] && (values[k] < result)) begin
                result = values[k];
            end
        end
    end

    // Every valid neighbor that holds the winning root
    always_comb begin
        for (int k = 0; k < NEIGHBOR_COUNT; k++) begin
            output_valids[k] = valids[k] && (values[k] == result);
        end
    end

endmodule

// ==== hdl/processing_unit.sv ====
`timescale 1ns/1ps

module processing_unit #(
    parameter int INDEX = 0
) (
    input  logic                                           clk,
    input  logic                                           reset,
    input  uf_pkg::stage_t                                 global_stage,
    input  logic                                           measurement,
    input  uf_pkg::neighbor_vec_t                          neighbor_fully_grown,
    input  uf_pkg::neighbor_vec_t                          neighbor_is_boundary,
    input  uf_pkg::pe_link_t [uf_pkg::NEIGHBOR_COUNT-1:0]  neighbor_in,
    output uf_pkg::pe_link_t [uf_pkg::NEIGHBOR_COUNT-1:0]  neighbor_out,
    output logic                                           neighbor_increase,
    output uf_pkg::neighbor_vec_t                          neighbor_is_error,
    output logic                                           odd,
    output logic                                           busy
);

    import uf_pkg::*;

    localparam root_addr_t OWN_ADDR = root_addr_t'(INDEX) | root_addr_t'(1 << (ADDR_W - 1));
    localparam root_addr_t BOUNDARY_ADDR = {1'b0, OWN_ADDR[ADDR_W-2:0]};

    stage_t stage;
    stage_t last_stage;
    logic m;
    root_addr_t root;
    neighbor_vec_t parent_vector;
    logic cluster_parity;

    root_addr_t [NEIGHBOR_COUNT-1:0] neighbor_root;
    neighbor_vec_t neighbor_parent;
    neighbor_vec_t neighbor_odd;
    neighbor_vec_t child_parity;

    root_addr_t min_root;
    neighbor_vec_t min_valids;
    root_addr_t root_modified;
    logic touching_boundary;
    logic next_cluster_parity;
    logic next_odd;
    logic adopt_neighbor;
    logic adopt_boundary;
    neighbor_vec_t first_boundary;
    neighbor_vec_t error_internal;
    neighbor_vec_t error_border;

    // Split the incoming links and build the outgoing ones
    always_comb begin
        for (int k = 0; k < NEIGHBOR_COUNT; k++) begin
            neighbor_root[k]   = neighbor_in[k].root;
            neighbor_parent[k] = neighbor_in[k].parent;
            neighbor_odd[k]    = neighbor_in[k].odd;
            child_parity[k]    = neighbor_in[k].cluster_parity;

            neighbor_out[k].root           = root;
            neighbor_out[k].parent         = parent_vector[k];
            neighbor_out[k].odd            = odd;
            neighbor_out[k].cluster_parity = cluster_parity;
        end
    end

    // Local copy of the stage, one cycle behind the controller
    always_ff @(posedge clk) begin
        if (reset) begin
            stage      <= STAGE_IDLE;
            last_stage <= STAGE_IDLE;
        end else begin
            stage      <= global_stage;
            last_stage <= stage;
        end
    end

    // Odd clusters grow once per round
    assign neighbor_increase = (stage == STAGE_GROW) && (last_stage != STAGE_GROW) && odd;

    // Only fully grown interior edges offer a root
    min_root_select root_select_inst (
        .values        (neighbor_root),
        .valids        (neighbor_fully_grown & ~neighbor_is_boundary),
        .result        (min_root),
        .output_valids (min_valids)
    );

    assign touching_boundary = |neighbor_is_boundary;
    assign root_modified = touching_boundary ? BOUNDARY_ADDR : root;

    assign adopt_neighbor = (|min_valids) && (min_root < root_modified) && (min_root < root);
    assign adopt_boundary = !adopt_neighbor && (root_modified < root);

    // Subtree parity from the children, odd flows down from the parent
    assign next_cluster_parity = (^(neighbor_parent & child_parity)) ^ m;
    assign next_odd = (|parent_vector) ? |(parent_vector & neighbor_odd)
                                       : next_cluster_parity && !touching_boundary;

    always_ff @(posedge clk) begin
        if (reset) begin
            parent_vector <= '0;
            odd           <= 1'b0;
        end else if (stage == STAGE_MEASUREMENT_LOADING) begin
            parent_vector <= '0;
            odd           <= measurement;
        end else if (stage == STAGE_MERGE) begin
            if (adopt_neighbor) begin
                parent_vector <= min_valids;
            end else if (adopt_boundary) begin
                parent_vector <= '0;
            end
            odd <= next_odd;
        end
    end

    always_ff @(posedge clk) begin
        if (stage == STAGE_MEASUREMENT_LOADING) begin
            m              <= measurement;
            root           <= OWN_ADDR;
            cluster_parity <= measurement;
        end else if (stage == STAGE_MERGE) begin
            if (adopt_neighbor) begin
                root <= min_root;
            end else if (adopt_boundary) begin
                root <= root_modified;
            end
            cluster_parity <= next_cluster_parity;
        end
    end

    // Busy whenever a merge step still moves something
    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
        end else if (stage == STAGE_MERGE) begin
            busy <= adopt_neighbor || adopt_boundary ||
                    (next_cluster_parity != cluster_parity) || (next_odd != odd);
        end
    end

    // Peeling marks the parent edge, or the first boundary edge for a root
    assign first_boundary = neighbor_is_boundary & (~neighbor_is_boundary + 1'b1);

    always_comb begin
        error_internal = '0;
        error_border   = '0;
        if ((stage == STAGE_PEELING) && cluster_parity) begin
            error_internal = parent_vector;
            if (!(|parent_vector)) begin
                error_border = first_boundary;
            end
        end
    end

    assign neighbor_is_error = error_internal | error_border;

    // A unit in a line has at most one parent
    assert property (@(posedge clk) disable iff (reset) $onehot0(parent_vector));

endmodule

// ==== hdl/stage_controller.sv ====
`timescale 1ns/1ps

module stage_controller #(
    parameter int CODE_DISTANCE = 7
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     syndrome_valid,
    input  logic [CODE_DISTANCE-2:0] syndrome,
    input  logic [CODE_DISTANCE-2:0] unit_busy,
    input  logic [CODE_DISTANCE-2:0] unit_odd,
    input  logic [CODE_DISTANCE-1:0] edge_correction,
    output uf_pkg::stage_t           global_stage,
    output logic [CODE_DISTANCE-2:0] measurement,
    output logic                     correction_valid,
    output logic [CODE_DISTANCE-1:0] correction
);

    import uf_pkg::*;

    localparam int ROUND_W = $clog2(CODE_DISTANCE + 1);

    logic [ROUND_W-1:0] round_count;
    logic [1:0] merge_cycles;
    logic quiet_last;
    logic peel_second;
    logic any_busy;
    logic any_odd;
    logic merge_done;

    assign any_busy = |unit_busy;
    assign any_odd  = |unit_odd;

    // At least 3 merge cycles and 2 quiet ones in a row
    assign merge_done = (merge_cycles == 2'd2) && !any_busy && quiet_last;

    always_ff @(posedge clk) begin
        if (reset) begin
            global_stage     <= STAGE_IDLE;
            round_count      <= '0;
            merge_cycles     <= '0;
            quiet_last       <= 1'b0;
            peel_second      <= 1'b0;
            correction_valid <= 1'b0;
        end else begin
            correction_valid <= 1'b0;
            case (global_stage)
                STAGE_IDLE: begin
                    round_count <= '0;
                    if (syndrome_valid) begin
                        global_stage <= STAGE_MEASUREMENT_LOADING;
                    end
                end
                STAGE_MEASUREMENT_LOADING: global_stage <= STAGE_GROW;
                STAGE_GROW: begin
                    round_count  <= round_count + 1'b1;
                    merge_cycles <= '0;
                    quiet_last   <= 1'b0;
                    global_stage <= STAGE_MERGE;
                end
                STAGE_MERGE: begin
                    if (merge_cycles != 2'd2) begin
                        merge_cycles <= merge_cycles + 1'b1;
                    end
                    quiet_last <= !any_busy;
                    if (merge_done) begin
                        peel_second  <= 1'b0;
                        global_stage <= (any_odd && (round_count < CODE_DISTANCE)) ?
                                        STAGE_GROW : STAGE_PEELING;
                    end
                end
                STAGE_PEELING: begin
                    peel_second <= 1'b1;
                    if (peel_second) begin
                        correction_valid <= 1'b1;
                        global_stage     <= STAGE_RESULT;
                    end
                end
                default: global_stage <= STAGE_IDLE;
            endcase
        end
    end

    // Syndrome and correction registers
    always_ff @(posedge clk) begin
        if ((global_stage == STAGE_IDLE) && syndrome_valid) begin
            measurement <= syndrome;
        end
        if ((global_stage == STAGE_PEELING) && peel_second) begin
            correction <= edge_correction;
        end
    end

    // Merge only ends once every unit has settled
    assert property (@(posedge clk) disable iff (reset)
        (global_stage == STAGE_PEELING) |-> !any_busy);

endmodule

// ==== hdl/uf_decoder_top.sv ====
`timescale 1ns/1ps

module uf_decoder_top #(
    parameter int CODE_DISTANCE = 7
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     syndrome_valid,
    input  logic [CODE_DISTANCE-2:0] syndrome,
    output logic                     correction_valid,
    output logic [CODE_DISTANCE-1:0] correction
);

    import uf_pkg::*;

    localparam int UNITS = CODE_DISTANCE - 1;

    stage_t global_stage;
    logic [UNITS-1:0] measurement;
    logic [UNITS-1:0] unit_busy;
    logic [UNITS-1:0] unit_odd;
    logic [CODE_DISTANCE-1:0] edge_fully_grown;
    logic [CODE_DISTANCE-1:0] edge_is_boundary;
    logic [CODE_DISTANCE-1:0] edge_correction;

    // Padded lines, index k of increase_pad and the right-going lines holds unit k-1
    logic [UNITS+1:0] increase_pad;
    logic [UNITS:0] error_right_pad;
    logic [UNITS:0] error_left_pad;
    pe_link_t [UNITS:0] link_right_pad;
    pe_link_t [UNITS:0] link_left_pad;

    // Nothing beyond the two ends
    assign increase_pad[0]       = 1'b0;
    assign increase_pad[UNITS+1] = 1'b0;
    assign error_right_pad[0]    = 1'b0;
    assign error_left_pad[UNITS] = 1'b0;
    assign link_right_pad[0]     = '0;
    assign link_left_pad[UNITS]  = '0;

    stage_controller #(
        .CODE_DISTANCE (CODE_DISTANCE)
    ) ctrl_inst (
        .clk              (clk),
        .reset            (reset),
        .syndrome_valid   (syndrome_valid),
        .syndrome         (syndrome),
        .unit_busy        (unit_busy),
        .unit_odd         (unit_odd),
        .edge_correction  (edge_correction),
        .global_stage     (global_stage),
        .measurement      (measurement),
        .correction_valid (correction_valid),
        .correction       (correction)
    );

    // Unit i sits between edge i and edge i+1
    for (genvar i = 0; i < UNITS; i++) begin : g_unit
        pe_link_t [NEIGHBOR_COUNT-1:0] link_out;
        neighbor_vec_t error_out;

        processing_unit #(
            .INDEX (i)
        ) unit_inst (
            .clk                  (clk),
            .reset                (reset),
            .global_stage         (global_stage),
            .measurement          (measurement[i]),
            .neighbor_fully_grown (edge_fully_grown[i+1:i]),
            .neighbor_is_boundary (edge_is_boundary[i+1:i]),
            .neighbor_in          ({link_left_pad[i+1], link_right_pad[i]}),
            .neighbor_out         (link_out),
            .neighbor_increase    (increase_pad[i+1]),
            .neighbor_is_error    (error_out),
            .odd                  (unit_odd[i]),
            .busy                 (unit_busy[i])
        );

        assign link_right_pad[i+1]  = link_out[1];
        assign link_left_pad[i]     = link_out[0];
        assign error_right_pad[i+1] = error_out[1];
        assign error_left_pad[i]    = error_out[0];
    end

    for (genvar j = 0; j < CODE_DISTANCE; j++) begin : g_edge
        edge_link #(
            .IS_BOUNDARY ((j == 0) || (j == CODE_DISTANCE - 1))
        ) edge_inst (
            .clk            (clk),
            .reset          (reset),
            .global_stage   (global_stage),
            .increase_left  (increase_pad[j]),
            .increase_right (increase_pad[j+1]),
            .error_left     (error_right_pad[j]),
            .error_right    (error_left_pad[j]),
            .fully_grown    (edge_fully_grown[j]),
            .is_boundary    (edge_is_boundary[j]),
            .correction     (edge_correction[j])
        );
    end

endmodule

// ==== hdl/uf_pkg.sv ====
package uf_pkg;

    // Global decoder stage, broadcast to every unit and edge
    typedef enum logic [2:0] {
        STAGE_IDLE                = 3'd0,
        STAGE_MEASUREMENT_LOADING = 3'd1,
        STAGE_GROW                = 3'd2,
        STAGE_MERGE               = 3'd3,
        STAGE_PEELING             = 3'd4,
        STAGE_RESULT              = 3'd5
    } stage_t;

    // Unit addresses carry the top bit set, boundary roots have it cleared
    localparam int ADDR_W = 5;
    typedef logic [ADDR_W-1:0] root_addr_t;

    // Index 0 is the left neighbor, index 1 the right one
    localparam int NEIGHBOR_COUNT = 2;
    typedef logic [NEIGHBOR_COUNT-1:0] neighbor_vec_t;

    // Edge growth runs from 0 to full
    typedef logic [1:0] growth_t;
    localparam growth_t GROWTH_FULL = 2'd2;

    // What a unit exposes to one neighbor
    typedef struct packed {
        root_addr_t root;
        logic       parent;
        logic       odd;
        logic       cluster_parity;
    } pe_link_t;

endpackage

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the union-find decoder testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_uf_decoder -f build.f -o tb_uf_decoder_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_uf_decoder_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# The run passes only if the testbench printed its pass line
if echo "$output" | grep -Fqx '>>> PASS'; then
    exit 0
fi
echo "Pass line not found in simulation output"
exit 1

// ==== tb/tb_uf_decoder.sv ====
`timescale 1ns/1ps

module tb_uf_decoder;

    localparam int CODE_DISTANCE = 7;
    localparam int TABLE_SIZE = 4;
    localparam int RANDOM_COUNT = 40;
    localparam int TIMEOUT_CYCLES = 500;

    logic clk;
    logic reset;
    logic syndrome_valid;
    logic [CODE_DISTANCE-2:0] syndrome;
    logic correction_valid;
    logic [CODE_DISTANCE-1:0] correction;

    int checks;
    int errors;
    int timeouts;
    logic [31:0] lcg_state;

    // Syndromes with their expected corrections
    logic [CODE_DISTANCE-2:0] table_syndrome [TABLE_SIZE];
    logic [CODE_DISTANCE-1:0] table_correction [TABLE_SIZE];

    uf_decoder_top #(
        .CODE_DISTANCE (CODE_DISTANCE)
    ) dut_i (
        .clk              (clk),
        .reset            (reset),
        .syndrome_valid   (syndrome_valid),
        .syndrome         (syndrome),
        .correction_valid (correction_valid),
        .correction       (correction)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic check_correction(input string name, input logic [CODE_DISTANCE-1:0] got,
                                    input logic [CODE_DISTANCE-1:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("FAIL %s: got 0x%0h expected 0x%0h", name, got, expected);
        end
    endtask

    task automatic check_syndrome(input string name, input logic [CODE_DISTANCE-2:0] got,
                                  input logic [CODE_DISTANCE-2:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("FAIL %s: got 0x%0h expected 0x%0h", name, got, expected);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("FAIL %s: got 0x%0h expected 0x%0h", name, got, expected);
        end
    endtask

    // One-cycle strobe, driven just after the clock edge
    task automatic send_syndrome(input logic [CODE_DISTANCE-2:0] value);
        @(posedge clk);
        #1;
        syndrome_valid = 1'b1;
        syndrome       = value;
        @(posedge clk);
        #1;
        syndrome_valid = 1'b0;
        syndrome       = '0;
    endtask

    task automatic wait_correction(output bit seen);
        int cycles;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && (cycles < TIMEOUT_CYCLES)) begin
            @(posedge clk);
            #1;
            cycles++;
            if (correction_valid) begin
                seen = 1'b1;
            end
        end
        if (!seen) begin
            timeouts++;
            $display("Timed out after %0d cycles waiting for correction_valid", TIMEOUT_CYCLES);
        end
    endtask

    // Idle gap first so the controller is back in IDLE when the strobe lands
    task automatic decode(input logic [CODE_DISTANCE-2:0] value,
                          output logic [CODE_DISTANCE-1:0] result, output bit seen);
        repeat (2) @(posedge clk);
        send_syndrome(value);
        wait_correction(seen);
        result = correction;
    endtask

    initial begin
        logic [CODE_DISTANCE-2:0] syn;
        logic [CODE_DISTANCE-2:0] rebuilt;
        logic [CODE_DISTANCE-1:0] got;
        logic extra_pulse;
        bit seen;

        clk            = 1'b0;
        reset          = 1'b1;
        syndrome_valid = 1'b0;
        syndrome       = '0;
        checks         = 0;
        errors         = 0;
        timeouts       = 0;
        lcg_state      = 32'd67978;

        // Empty, boundary on each end, and an adjacent pair merging on root 1
        table_syndrome[0] = 6'b000000;
        table_correction[0] = 7'b0000000;
        table_syndrome[1] = 6'b000001;
        table_correction[1] = 7'b0000001;
        table_syndrome[2] = 6'b100000;
        table_correction[2] = 7'b1000000;
        table_syndrome[3] = 6'b000110;
        table_correction[3] = 7'b0000100;

        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;

        // Quiet after reset
        repeat (10) begin
            @(posedge clk);
            #1;
            check_flag("correction_valid after reset", correction_valid, 1'b0);
        end

        for (int i = 0; i < TABLE_SIZE; i++) begin
            decode(table_syndrome[i], got, seen);
            if (seen) begin
                check_correction($sformatf("correction case %0d", i), got, table_correction[i]);
            end
        end

        // Any valid correction has boundary parity equal to the syndrome
        for (int n = 0; n < RANDOM_COUNT; n++) begin
            lcg_state = lcg_next(lcg_state);
            syn = lcg_state[16 +: CODE_DISTANCE-1];
            decode(syn, got, seen);
            if (seen) begin
                for (int k = 0; k < CODE_DISTANCE - 1; k++) begin
                    rebuilt[k] = got[k] ^ got[k+1];
                end
                check_syndrome($sformatf("syndrome from correction %0d", n), rebuilt, syn);
            end
        end

        // Second strobe lands mid-decode and must be dropped
        repeat (2) @(posedge clk);
        send_syndrome(table_syndrome[1]);
        repeat (3) @(posedge clk);
        send_syndrome(table_syndrome[3]);
        wait_correction(seen);
        if (seen) begin
            check_correction("correction with overlapping strobe", correction,
                             table_correction[1]);
        end
        extra_pulse = 1'b0;
        repeat (40) begin
            @(posedge clk);
            #1;
            if (correction_valid) begin
                extra_pulse = 1'b1;
            end
        end
        check_flag("extra correction_valid", extra_pulse, 1'b0);

        $display("Checks: %0d  errors: %0d  timeouts: %0d", checks, errors, timeouts);
        if ((errors == 0) && (timeouts == 0)) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
